// File: include/dlxCore_defines.svh
//**********************************************************
// fixed widths of the execution core, no module overrides them
// register count and address width must agree (8 regs, 3 bits)
//**********************************************************

`ifndef DLXCORE_DEFINES_SVH
`define DLXCORE_DEFINES_SVH

// width of one data word
`define DLX_DATA_WIDTH 32

// number of architectural registers, r0 included
`define DLX_REG_COUNT 8

// bits needed to name a register
`define DLX_REG_ADDR_WIDTH 3

// width of the immediate field of an instruction
`define DLX_IMM_WIDTH 16

`endif

// File: design/dlxPkg.sv
//**********************************************************
// shared types of the core, widths come from the defines header
// opcode encodings are fixed, the driver of the core must match them
//**********************************************************

`include "dlxCore_defines.svh"

`default_nettype none

package dlxPkg;

        // data word and register number
        typedef logic [`DLX_DATA_WIDTH-1:0] word_t;
        typedef logic [`DLX_REG_ADDR_WIDTH-1:0] regAddr_t;

        // raw immediate field, sign handled by the controller
        typedef logic [`DLX_IMM_WIDTH-1:0] imm_t;

        //**********************************************************
        // decoded instruction opcodes
        //**********************************************************
        typedef enum logic [3:0] {
                opAdd  = 4'd0,
                opSub  = 4'd1,
                opAnd  = 4'd2,
                opOr   = 4'd3,
                opXor  = 4'd4,
                opSlt  = 4'd5,
                opSll  = 4'd6,
                opSrl  = 4'd7,
                opAddi = 4'd8,
                opLhi  = 4'd9
        } opcode_t;

        // alu function select, load-high rides on fnOr
        typedef enum logic [2:0] {
                fnAdd = 3'd0,
                fnSub = 3'd1,
                fnAnd = 3'd2,
                fnOr  = 3'd3,
                fnXor = 3'd4,
                fnSlt = 3'd5,
                fnSll = 3'd6,
                fnSrl = 3'd7
        } aluFunc_t;

        // three phases of one instruction
        typedef enum logic [1:0] {
                stIdle,
                stExec,
                stWrite
        } ctrlState_t;

endpackage

`default_nettype wire

// File: design/regPortIf.sv
//**********************************************************
// read and write ports of the register file
// reads are combinational, one write per clock
//**********************************************************

`default_nettype none

interface regPortIf;

        // register numbers for the two reads
        dlxPkg::regAddr_t rdReg1;
        dlxPkg::regAddr_t rdReg2;

        // write port
        dlxPkg::regAddr_t wrtReg;
        dlxPkg::word_t    wrtData;
        logic             regWrite;

        // read data back to the controller
        dlxPkg::word_t    r1Out;
        dlxPkg::word_t    r2Out;

        // controller side
        modport ctrl (
                output rdReg1, rdReg2, wrtReg, wrtData, regWrite,
                input  r1Out, r2Out
        );

        // register file side
        modport store (
                input  rdReg1, rdReg2, wrtReg, wrtData, regWrite,
                output r1Out, r2Out
        );

endinterface

`default_nettype wire

// File: design/aluIf.sv
//**********************************************************
// operands and result between controller and alu
// result and zero hold until the next start
//**********************************************************

`default_nettype none

interface aluIf;

        // operands and function, valid while start is high
        dlxPkg::word_t    opA;
        dlxPkg::word_t    opB;
        dlxPkg::aluFunc_t func;
        logic             start;

        // registered outputs of the alu
        dlxPkg::word_t    result;
        logic             zero;

        modport ctrl (
                output opA, opB, func, start,
                input  result, zero
        );

        modport unit (
                input  opA, opB, func, start,
                output result, zero
        );

endinterface

`default_nettype wire

// File: design/regFile.sv
//**********************************************************
// eight registers, r0 has no storage and always reads zero
// reads in zero cycles, write lands at the rising edge
//**********************************************************

`include "dlxCore_defines.svh"

`default_nettype none

module regFile (
        input  logic      Clk,
        input  logic      reset,
        regPortIf.store   regs
);

        // only r1 to r7 are stored
        dlxPkg::word_t regArray [1:`DLX_REG_COUNT-1];

        //**********************************************************
        // write port
        //**********************************************************
        always_ff @(posedge Clk) begin
                if (reset) begin
                        for (int i = 1; i < `DLX_REG_COUNT; i++) begin
                                regArray[i] <= '0;
                        end
                end else if (regs.regWrite && (regs.wrtReg != '0)) begin
                        // writes to r0 fall through here and are lost
                        regArray[regs.wrtReg] <= regs.wrtData;
                end
        end

        //**********************************************************
        // read ports, selected by register number
        //**********************************************************
        always_comb begin
                regs.r1Out = '0;
                if (regs.rdReg1 != '0) begin
                        regs.r1Out = regArray[regs.rdReg1];
                end
        end

        always_comb begin
                regs.r2Out = '0;
                if (regs.rdReg2 != '0) begin
                        regs.r2Out = regArray[regs.rdReg2];
                end
        end

        // write strobe must be clean once out of reset
        assert property (@(posedge Clk) disable iff (reset)
                !$isunknown(regs.regWrite));

        // r0 stays zero even right after a write aimed at it
        assert property (@(posedge Clk) disable iff (reset)
                (regs.regWrite && regs.wrtReg == '0) |=>
                        ((regs.rdReg1 != '0 || regs.r1Out == '0) &&
                         (regs.rdReg2 != '0 || regs.r2Out == '0)));

endmodule

`default_nettype wire

// File: design/aluUnit.sv
//**********************************************************
// one-cycle registered alu, result captured when start is high
// shifts use only the low bits of opB, slt compares signed
//**********************************************************

`include "dlxCore_defines.svh"

`default_nettype none

module aluUnit (
        input  logic  Clk,
        input  logic  reset,
        aluIf.unit    alu
);

        // shift amount bits, 5 for a 32-bit word
        localparam int ShamtWidth = $clog2(`DLX_DATA_WIDTH);

        dlxPkg::word_t         nextResult;
        logic [ShamtWidth-1:0] shamt;
        logic                  lessThan;

        assign shamt = alu.opB[ShamtWidth-1:0];

        // two's complement signed compare
        assign lessThan = ($signed(alu.opA) < $signed(alu.opB));

        //**********************************************************
        // function select
        //**********************************************************
        always_comb begin
                case (alu.func)
                        dlxPkg::fnAdd: nextResult = alu.opA + alu.opB;
                        dlxPkg::fnSub: nextResult = alu.opA - alu.opB;
                        dlxPkg::fnAnd: nextResult = alu.opA & alu.opB;
                        // also carries load-high, opA is zero then
                        dlxPkg::fnOr:  nextResult = alu.opA | alu.opB;
                        dlxPkg::fnXor: nextResult = alu.opA ^ alu.opB;
                        dlxPkg::fnSlt: begin
                                nextResult = {{(`DLX_DATA_WIDTH-1){1'b0}}, lessThan};
                        end
                        dlxPkg::fnSll: nextResult = alu.opA << shamt;
                        dlxPkg::fnSrl: nextResult = alu.opA >> shamt;
                        default:       nextResult = '0;
                endcase
        end

        //**********************************************************
        // result and zero flag registers
        //**********************************************************
        always_ff @(posedge Clk) begin
                if (reset) begin
                        alu.result <= '0;
                        alu.zero   <= 1'b1;
                end else if (alu.start) begin
                        alu.result <= nextResult;
                        // flag describes the value about to be written
                        alu.zero   <= (nextResult == '0);
                end
        end

        // function code must be a defined encoding when used
        assert property (@(posedge Clk) disable iff (reset)
                alu.start |-> alu.func inside {
                        dlxPkg::fnAdd, dlxPkg::fnSub, dlxPkg::fnAnd, dlxPkg::fnOr,
                        dlxPkg::fnXor, dlxPkg::fnSlt, dlxPkg::fnSll, dlxPkg::fnSrl});

endmodule

`default_nettype wire

// File: design/execControl.sv
//**********************************************************
// instruction latch and three-phase control fsm
// one instruction in flight and instrValid ignored while busy
// done is a single-cycle pulse without back-pressure
//**********************************************************

`include "dlxCore_defines.svh"

`default_nettype none

module execControl (
        input  logic              Clk,
        input  logic              reset,
        input  logic              instrValid,
        input  dlxPkg::opcode_t   opcode,
        input  dlxPkg::regAddr_t  rd,
        input  dlxPkg::regAddr_t  rs1,
        input  dlxPkg::regAddr_t  rs2,
        input  dlxPkg::imm_t      imm,
        output logic              ready,
        output logic              done,
        regPortIf.ctrl            regs,
        aluIf.ctrl                alu
);

        dlxPkg::ctrlState_t state;
        dlxPkg::ctrlState_t nextState;
        logic               accept;

        // latched instruction fields
        dlxPkg::opcode_t    opcodeQ;
        dlxPkg::regAddr_t   rdQ;
        dlxPkg::regAddr_t   rs1Q;
        dlxPkg::regAddr_t   rs2Q;
        dlxPkg::imm_t       immQ;

        // immediate forms offered to opB
        dlxPkg::word_t      immSext;
        dlxPkg::word_t      immHigh;

        assign accept = instrValid && ready;

        //**********************************************************
        // state register and next state
        //**********************************************************
        always_ff @(posedge Clk) begin
                if (reset) begin
                        state <= dlxPkg::stIdle;
                end else begin
                        state <= nextState;
                end
        end

        always_comb begin
                nextState = state;
                case (state)
                        dlxPkg::stIdle:  if (accept) nextState = dlxPkg::stExec;
                        dlxPkg::stExec:  nextState = dlxPkg::stWrite;
                        dlxPkg::stWrite: nextState = dlxPkg::stIdle;
                        default:         nextState = dlxPkg::stIdle;
                endcase
        end

        // capture fields at the acceptance edge only
        always_ff @(posedge Clk) begin
                if (accept) begin
                        opcodeQ <= opcode;
                        rdQ     <= rd;
                        rs1Q    <= rs1;
                        rs2Q    <= rs2;
                        immQ    <= imm;
                end
        end

        //**********************************************************
        // opcode decode and operand select
        //**********************************************************
        assign immSext = {{(`DLX_DATA_WIDTH-`DLX_IMM_WIDTH){immQ[`DLX_IMM_WIDTH-1]}}, immQ};
        assign immHigh = {immQ, {(`DLX_DATA_WIDTH-`DLX_IMM_WIDTH){1'b0}}};

        always_comb begin
                alu.opA  = regs.r1Out;
                alu.opB  = regs.r2Out;
                alu.func = dlxPkg::fnAdd;
                case (opcodeQ)
                        dlxPkg::opAdd:  alu.func = dlxPkg::fnAdd;
                        dlxPkg::opSub:  alu.func = dlxPkg::fnSub;
                        dlxPkg::opAnd:  alu.func = dlxPkg::fnAnd;
                        dlxPkg::opOr:   alu.func = dlxPkg::fnOr;
                        dlxPkg::opXor:  alu.func = dlxPkg::fnXor;
                        dlxPkg::opSlt:  alu.func = dlxPkg::fnSlt;
                        dlxPkg::opSll:  alu.func = dlxPkg::fnSll;
                        dlxPkg::opSrl:  alu.func = dlxPkg::fnSrl;
                        dlxPkg::opAddi: alu.opB  = immSext;
                        dlxPkg::opLhi: begin
                                // zero | (imm << 16)
                                alu.opA  = '0;
                                alu.opB  = immHigh;
                                alu.func = dlxPkg::fnOr;
                        end
                        // undefined codes behave as add
                        default:        alu.func = dlxPkg::fnAdd;
                endcase
        end

        //**********************************************************
        // strobes to the register file and alu
        //**********************************************************
        assign regs.rdReg1   = rs1Q;
        assign regs.rdReg2   = rs2Q;
        assign regs.wrtReg   = rdQ;
        assign regs.wrtData  = alu.result;
        assign regs.regWrite = (state == dlxPkg::stWrite);

        assign alu.start = (state == dlxPkg::stExec);
        assign ready     = (state == dlxPkg::stIdle);
        assign done      = (state == dlxPkg::stWrite);

        // done is a pulse and is followed by ready
        assert property (@(posedge Clk) disable iff (reset)
                done |=> (!done && ready));

        // a register write only follows an alu start
        assert property (@(posedge Clk) disable iff (reset)
                regs.regWrite |-> $past(alu.start));

endmodule

`default_nettype wire

// File: design/dlxCore.sv
//**********************************************************
// multi-cycle execution core, one decoded instruction at a time
// no fetch, memory, branches or hazard logic
//**********************************************************

`default_nettype none

module dlxCore (
        input  logic              Clk,
        input  logic              reset,
        input  logic              instrValid,
        input  dlxPkg::opcode_t   opcode,
        input  dlxPkg::regAddr_t  rd,
        input  dlxPkg::regAddr_t  rs1,
        input  dlxPkg::regAddr_t  rs2,
        input  dlxPkg::imm_t      imm,
        output logic              ready,
        output logic              done,
        output dlxPkg::word_t     result,
        output logic              zero
);

        // internal buses
        regPortIf regBus ();
        aluIf     aluBus ();

        //**********************************************************
        // datapath blocks
        //**********************************************************
        regFile regFile_i (
                .Clk   (Clk),
                .reset (reset),
                .regs  (regBus.store)
        );

        aluUnit aluUnit_i (
                .Clk   (Clk),
                .reset (reset),
                .alu   (aluBus.unit)
        );

        // sequencing of each instruction
        execControl execControl_i (
                .Clk        (Clk),
                .reset      (reset),
                .instrValid (instrValid),
                .opcode     (opcode),
                .rd         (rd),
                .rs1        (rs1),
                .rs2        (rs2),
                .imm        (imm),
                .ready      (ready),
                .done       (done),
                .regs       (regBus.ctrl),
                .alu        (aluBus.ctrl)
        );

        // reported values are the alu registers, valid while done
        assign result = aluBus.result;
        assign zero   = aluBus.zero;

endmodule

`default_nettype wire

// File: tb/dlxCoreTb.sv
//**********************************************************
// seeded random instruction stream against a register model
// inputs move on the falling edge where outputs are also sampled
// done is expected in the cycle after the exec cycle
//**********************************************************

`include "dlxCore_defines.svh"

`default_nettype none

module dlxCoreTb;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int NumRandom   = 400;
        localparam int NumDirected = 16;
        localparam int ClkPeriod   = 40;
        // four cycles per instruction plus reset and slack
        localparam int WatchdogNs  = (NumRandom + NumDirected) * 4 * ClkPeriod + 20 * ClkPeriod;

        logic              Clk;
        logic              reset;
        logic              instrValid;
        dlxPkg::opcode_t   opcode;
        dlxPkg::regAddr_t  rd;
        dlxPkg::regAddr_t  rs1;
        dlxPkg::regAddr_t  rs2;
        dlxPkg::imm_t      imm;
        logic              ready;
        logic              done;
        dlxPkg::word_t     result;
        logic              zero;

        // reference copy of the register file where r0 is never written
        dlxPkg::word_t     model [0:`DLX_REG_COUNT-1];
        integer            seed;
        string             curInstr;
        dlxPkg::regAddr_t  lastRd;

        dlxCore dlxCore_i (
                .Clk        (Clk),
                .reset      (reset),
                .instrValid (instrValid),
                .opcode     (opcode),
                .rd         (rd),
                .rs1        (rs1),
                .rs2        (rs2),
                .imm        (imm),
                .ready      (ready),
                .done       (done),
                .result     (result),
                .zero       (zero)
        );

        always #(ClkPeriod / 2) Clk = ~Clk;

        //**********************************************************
        // reference semantics of one instruction
        //**********************************************************
        function automatic dlxPkg::word_t modelAlu(input dlxPkg::opcode_t op,
                        input dlxPkg::word_t a, input dlxPkg::word_t b, input dlxPkg::imm_t im);
                dlxPkg::word_t r;
                case (op)
                        dlxPkg::opAdd:  r = a + b;
                        dlxPkg::opSub:  r = a - b;
                        dlxPkg::opAnd:  r = a & b;
                        dlxPkg::opOr:   r = a | b;
                        dlxPkg::opXor:  r = a ^ b;
                        // signed compare of two's complement words
                        dlxPkg::opSlt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        dlxPkg::opSll:  r = a << b[4:0];
                        dlxPkg::opSrl:  r = a >> b[4:0];
                        dlxPkg::opAddi: r = a + {{16{im[15]}}, im};
                        dlxPkg::opLhi:  r = {im, 16'h0000};
                        default:        r = 'x;
                endcase
                return r;
        endfunction

        //**********************************************************
        // compare tasks
        //**********************************************************
        task automatic checkResult(input dlxPkg::word_t got, input dlxPkg::word_t exp,
                        input string what);
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %h expected %h in %s",
                                $time, what, got, exp, curInstr);
                        $display("test failed");
                        $fatal(1, "result compare stopped the run");
                end
        endtask

        task automatic checkZero(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %b expected %b in %s",
                                $time, what, got, exp, curInstr);
                        $display("test failed");
                        $fatal(1, "zero flag compare stopped the run");
                end
        endtask

        // ready and done timing
        task automatic checkStrobe(input logic got, input logic exp, input string what);
                if (got !== exp) begin
                        $display("MISMATCH at %0t ns: %s got %b expected %b in %s",
                                $time, what, got, exp, curInstr);
                        $display("test failed");
                        $fatal(1, "strobe compare stopped the run");
                end
        endtask

        //**********************************************************
        // instruction drivers
        //**********************************************************
        task automatic waitReady();
                int waited;
                waited = 0;
                while (ready !== 1'b1) begin
                        if (waited == 8) begin
                                $display("core never raised ready within 8 cycles at %0t ns", $time);
                                $display("test failed");
                                $fatal(1, "core stuck busy");
                        end else begin
                                @(negedge Clk);
                                waited++;
                        end
                end
        endtask

        // one instruction with an optional stray valid while busy
        task automatic execInstr(input dlxPkg::opcode_t op, input dlxPkg::regAddr_t d,
                        input dlxPkg::regAddr_t s1, input dlxPkg::regAddr_t s2,
                        input dlxPkg::imm_t im, input logic noise);
                dlxPkg::word_t expVal;
                waitReady();
                expVal   = modelAlu(op, model[s1], model[s2], im);
                curInstr = $sformatf("%s r%0d, r%0d, r%0d, imm %h", op.name(), d, s1, s2, im);
                instrValid = 1'b1;
                opcode     = op;
                rd         = d;
                rs1        = s1;
                rs2        = s2;
                imm        = im;
                @(negedge Clk);
                // accepted at the last rising edge so the core is now in exec
                checkStrobe(ready, 1'b0, "ready after accept");
                checkStrobe(done, 1'b0, "done in exec cycle");
                // junk fields with valid high while the core is busy and latches nothing
                instrValid = noise;
                if (noise) begin
                        opcode = dlxPkg::opcode_t'($unsigned($random(seed)) % 10);
                        rd     = dlxPkg::regAddr_t'($random(seed));
                        rs1    = dlxPkg::regAddr_t'($random(seed));
                        rs2    = dlxPkg::regAddr_t'($random(seed));
                        imm    = dlxPkg::imm_t'($random(seed));
                end
                @(negedge Clk);
                checkStrobe(done, 1'b1, "done pulse");
                checkResult(result, expVal, "result");
                checkZero(zero, (expVal == '0), "zero flag");
                if (d != '0) begin
                        model[d] = expVal;
                end
                @(negedge Clk);
                instrValid = 1'b0;
                checkStrobe(done, 1'b0, "done after pulse");
                checkStrobe(ready, 1'b1, "ready after write");
                lastRd = d;
        endtask

        task automatic randomInstr();
                dlxPkg::opcode_t  op;
                dlxPkg::regAddr_t d;
                dlxPkg::regAddr_t s1;
                dlxPkg::regAddr_t s2;
                dlxPkg::imm_t     im;
                logic             noise;
                op = dlxPkg::opcode_t'($unsigned($random(seed)) % 10);
                d  = dlxPkg::regAddr_t'($random(seed));
                s1 = dlxPkg::regAddr_t'($random(seed));
                s2 = dlxPkg::regAddr_t'($random(seed));
                im = dlxPkg::imm_t'($random(seed));
                // bias toward reading the register just written
                if (($random(seed) & 3) == 0) begin
                        s1 = lastRd;
                end
                noise = 1'($random(seed));
                execInstr(op, d, s1, s2, im, noise);
        endtask

        //**********************************************************
        // main sequence
        //**********************************************************
        initial begin
                Clk        = 1'b0;
                reset      = 1'b1;
                instrValid = 1'b0;
                opcode     = dlxPkg::opAdd;
                rd         = '0;
                rs1        = '0;
                rs2        = '0;
                imm        = '0;
                seed       = 19;
                lastRd     = '0;
                curInstr   = "reset";
                for (int i = 0; i < `DLX_REG_COUNT; i++) begin
                        model[i] = '0;
                end
                repeat (8) @(negedge Clk);
                reset = 1'b0;
                checkStrobe(ready, 1'b1, "ready after reset");
                checkStrobe(done, 1'b0, "done after reset");

                // every register reads zero after reset
                for (int r = 0; r < `DLX_REG_COUNT; r++) begin
                        execInstr(dlxPkg::opAdd, dlxPkg::regAddr_t'(r), dlxPkg::regAddr_t'(r),
                                3'd0, 16'h0000, 1'b0);
                end

                // immediate forms with sign extension and upper half
                execInstr(dlxPkg::opAddi, 3'd1, 3'd0, 3'd0, 16'hfff0, 1'b0);
                execInstr(dlxPkg::opLhi, 3'd2, 3'd0, 3'd0, 16'h8001, 1'b1);
                // negative against zero where an unsigned compare disagrees
                execInstr(dlxPkg::opSlt, 3'd3, 3'd1, 3'd0, 16'h0000, 1'b0);

                // r0 write is lost and r0 then reads zero through add
                execInstr(dlxPkg::opLhi, 3'd0, 3'd0, 3'd0, 16'hffff, 1'b0);
                execInstr(dlxPkg::opAdd, 3'd4, 3'd0, 3'd0, 16'h0000, 1'b1);

                // shift by low 5 bits of a negative amount
                execInstr(dlxPkg::opSll, 3'd5, 3'd1, 3'd1, 16'h0000, 1'b0);

                for (int n = 0; n < NumRandom; n++) begin
                        randomInstr();
                end

                $display("test passed");
                $finish;
        end

        // watchdog
        initial begin
                #(WatchdogNs);
                $display("timeout: the run did not finish within %0d ns", WatchdogNs);
                $display("test failed");
                $fatal(1, "watchdog expired");
        end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
design/dlxPkg.sv
design/regPortIf.sv
design/aluIf.sv
design/regFile.sv
design/aluUnit.sv
design/execControl.sv
design/dlxCore.sv
tb/dlxCoreTb.sv

// File: Bender.yml
package:
  name: dlxCore

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/dlxPkg.sv
      - design/regPortIf.sv
      - design/aluIf.sv
      - design/regFile.sv
      - design/aluUnit.sv
      - design/execControl.sv
      - design/dlxCore.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/dlxCoreTb.sv
